// File: Makefile
# Verilator flow for the quad PLL subsystem

TOP       ?= quad_pll_subsys_tb
FILELIST  ?= quad_pll_subsys.f
SEED      ?= 1
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir
VERILATOR ?= verilator
JOBS      ?= 0

VFLAGS    = --timing --assert --top-module $(TOP) -f $(FILELIST)
PASS_TEXT = TEST RESULT: PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS)

sim:
	$(VERILATOR) --binary -j $(JOBS) -Mdir $(OBJ_DIR) $(VFLAGS)
	./$(OBJ_DIR)/V$(TOP) +verilator+seed+$(SEED) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: design/apb_if.sv
`timescale 1ns/1ps
`default_nettype none

// APB link between the control block and the PLL DRP port

interface apb_if import apb_pkg::*; (
	input wire pclk
);

	logic      psel;
	logic      penable;
	logic      pwrite;
	apb_addr_t paddr;
	apb_data_t pwdata;
	apb_data_t prdata;
	logic      pready;
	logic      pslverr;

	// Bus master side
	modport requester(input pclk, output psel, output penable, output pwrite,
		output paddr, output pwdata, input prdata, input pready, input pslverr);

	// Bus slave side
	modport completer(input pclk, input psel, input penable, input pwrite,
		input paddr, input pwdata, output prdata, output pready, output pslverr);

endinterface

`default_nettype wire

// File: design/apb_pkg.sv
`default_nettype none

// Bus side, widths and register map

package apb_pkg;

	localparam int addr_width = 12;
	localparam int data_width = 32;
	localparam int drp_width  = 16;	// DRP words are half a bus word

	typedef logic [addr_width-1:0] apb_addr_t;
	typedef logic [data_width-1:0] apb_data_t;
	typedef logic [drp_width-1:0]  drp_data_t;

	////////////////////////////////////////
	// Control window

	localparam apb_addr_t ctrl_addr        = 12'h000;
	localparam apb_addr_t status_addr      = 12'h004;
	localparam apb_addr_t sdm0_addr        = 12'h008;
	localparam apb_addr_t sdm1_addr        = 12'h00c;
	localparam apb_addr_t sdm_active0_addr = 12'h010;
	localparam apb_addr_t sdm_active1_addr = 12'h014;

	// DRP window, word index starts at bit 2
	localparam int drp_window_bit = 10;
	localparam int drp_word_lsb   = 2;

endpackage

`default_nettype wire

// File: design/pll_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module pll_ctrl import apb_pkg::*, qpll_pkg::*; (
	input wire                             pclk,
	input wire                             reset,

	// Host APB
	input wire                             psel,
	input wire                             penable,
	input wire                             pwrite,
	input wire apb_addr_t                  paddr,
	input wire apb_data_t                  pwdata,
	output apb_data_t                      prdata,
	output logic                           pready,
	output logic                           pslverr,

	// DRP window toward the PLL block
	apb_if.requester                       drp,

	// PLL control and status
	output logic [num_plls-1:0]            qpll_reset,
	output logic [num_plls-1:0]            sdm_reset,
	output refclk_sel_t                    refclk_sel0,
	output refclk_sel_t                    refclk_sel1,
	input wire pll_status_t [num_plls-1:0] pll_status,

	// SDM load path
	output logic [num_plls-1:0]            sdm_start,
	output sdm_word_t                      sdm_word0,
	output sdm_word_t                      sdm_word1,
	input wire [num_plls-1:0]              sdm_busy,
	input wire sdm_word_t                  sdm_active0,
	input wire sdm_word_t                  sdm_active1
);

	logic                in_drp;	// Address bit 10 picks the DRP side
	logic                access;	// Control window access phase
	logic [num_plls-1:0] chan_busy;
	logic [num_plls-1:0] sdm_wr;
	logic                ctrl_wr;
	logic                ctrl_err;
	apb_data_t           ctrl_rdata;
	apb_data_t           ctrl_word;
	apb_data_t           status_word;

	assign in_drp    = paddr[drp_window_bit];
	assign access    = psel & penable & ~in_drp;
	assign chan_busy = sdm_busy | sdm_start;	// Loader busy lags start by a cycle

	////////////////////////////////////////
	// Register images

	// Sel1 10:8, sel0 6:4, SDM resets 3:2, PLL resets 1:0
	assign ctrl_word = {21'b0, refclk_sel1, 1'b0, refclk_sel0, sdm_reset, qpll_reset};

	assign status_word = {26'b0, chan_busy,
		pll_status[1].refclk_lost, pll_status[0].refclk_lost,
		pll_status[1].lock, pll_status[0].lock};

	////////////////////////////////////////
	// Control window decode

	always_comb begin
		ctrl_rdata = '0;
		ctrl_err   = 1'b0;
		ctrl_wr    = 1'b0;
		sdm_wr     = '0;
		case (paddr)
			ctrl_addr: begin
				ctrl_rdata = ctrl_word;
				ctrl_wr    = pwrite;
			end
			status_addr:      ctrl_rdata = status_word;	// Read only
			sdm0_addr: begin
				ctrl_rdata = {{(data_width-sdm_width){1'b0}}, sdm_word0};
				if (pwrite && chan_busy[0])
					ctrl_err = 1'b1;	// Still loading, write dropped
				else
					sdm_wr[0] = pwrite;
			end
			sdm1_addr: begin
				ctrl_rdata = {{(data_width-sdm_width){1'b0}}, sdm_word1};
				if (pwrite && chan_busy[1])
					ctrl_err = 1'b1;
				else
					sdm_wr[1] = pwrite;
			end
			sdm_active0_addr: ctrl_rdata = {{(data_width-sdm_width){1'b0}}, sdm_active0};
			sdm_active1_addr: ctrl_rdata = {{(data_width-sdm_width){1'b0}}, sdm_active1};
			default:          ctrl_err = 1'b1;	// Unmapped, reads zero
		endcase
	end

	always_ff @(posedge pclk) begin
		sdm_start <= '0;	// One cycle strobe
		if (reset) begin
			qpll_reset  <= '1;	// PLLs and SDMs held in reset
			sdm_reset   <= '1;
			refclk_sel0 <= sel_local0;
			refclk_sel1 <= sel_local0;
			sdm_word0   <= '0;
			sdm_word1   <= '0;
		end else if (access) begin
			if (ctrl_wr) begin
				qpll_reset  <= pwdata[1:0];
				sdm_reset   <= pwdata[3:2];
				refclk_sel0 <= pwdata[6:4];
				refclk_sel1 <= pwdata[10:8];
			end
			if (sdm_wr[0]) begin
				sdm_word0    <= pwdata[sdm_width-1:0];
				sdm_start[0] <= 1'b1;
			end
			if (sdm_wr[1]) begin
				sdm_word1    <= pwdata[sdm_width-1:0];
				sdm_start[1] <= 1'b1;
			end
		end
	end

	////////////////////////////////////////
	// DRP forwarding and response mux

	assign drp.psel    = psel & in_drp;
	assign drp.penable = penable & in_drp;
	assign drp.pwrite  = pwrite;
	assign drp.paddr   = paddr;
	assign drp.pwdata  = pwdata;

	// Control side answers in the first access cycle
	assign pready  = psel & penable & (in_drp ? drp.pready : 1'b1);
	assign prdata  = in_drp ? drp.prdata : ctrl_rdata;
	assign pslverr = pready & (in_drp ? drp.pslverr : ctrl_err);

endmodule

`default_nettype wire

// File: design/qpll_pkg.sv
`default_nettype none

// PLL side of the subsystem

package qpll_pkg;

	localparam int num_plls      = 2;	// QPLL0 and QPLL1
	localparam int num_refclks   = 6;	// Local, north and south pairs
	localparam int sdm_width     = 25;
	localparam int sdm_min_pulse = 3;	// Shortest toggle the SDM accepts

	// Fractional-N word, 24 bit denominator plus sign
	typedef logic [sdm_width-1:0] sdm_word_t;

	// Reference mux select, 0 and 7 pick nothing
	typedef logic [2:0] refclk_sel_t;

	localparam refclk_sel_t sel_local0 = 3'd1;
	localparam refclk_sel_t sel_local1 = 3'd2;
	localparam refclk_sel_t sel_north0 = 3'd3;
	localparam refclk_sel_t sel_north1 = 3'd4;
	localparam refclk_sel_t sel_south0 = 3'd5;
	localparam refclk_sel_t sel_south1 = 3'd6;

	// Per PLL status bits
	typedef struct packed {
		logic lock;
		logic refclk_lost;
	} pll_status_t;

endpackage

`default_nettype wire

// File: design/quad_pll.sv
`timescale 1ns/1ps
`default_nettype none

// Behavioral stand-in for the quad common block

module quad_pll import apb_pkg::*, qpll_pkg::*; #(
	parameter int LOCK_CYCLES = 40,
	parameter int DRP_WORDS   = 16
) (
	apb_if.completer                  apb,	// DRP port, runs on apb.pclk
	input wire                        reset,
	input wire [num_refclks-1:0]      refclk_ok,	// Local 0/1, north 0/1, south 0/1
	input wire refclk_sel_t           refclk_sel0,
	input wire refclk_sel_t           refclk_sel1,
	input wire [num_plls-1:0]         qpll_reset,
	input wire [num_plls-1:0]         sdm_reset,
	input wire sdm_word_t             sdm_data0,
	input wire sdm_word_t             sdm_data1,
	input wire [num_plls-1:0]         sdm_toggle,
	output pll_status_t [num_plls-1:0] pll_status,
	output sdm_word_t                 sdm_active0,
	output sdm_word_t                 sdm_active1
);

	localparam int word_w  = $clog2(DRP_WORDS);
	localparam int lock_w  = $clog2(LOCK_CYCLES + 1);
	localparam int pulse_w = $clog2(sdm_min_pulse + 1);

	function automatic logic source_ok(refclk_sel_t sel, logic [num_refclks-1:0] ok);
		case (sel)
			sel_local0: source_ok = ok[0];
			sel_local1: source_ok = ok[1];
			sel_north0: source_ok = ok[2];
			sel_north1: source_ok = ok[3];
			sel_south0: source_ok = ok[4];
			sel_south1: source_ok = ok[5];
			default:    source_ok = 1'b0;	// No source selected
		endcase
	endfunction

	////////////////////////////////////////
	// DRP space

	drp_data_t         ram [DRP_WORDS];
	drp_data_t         rd_q;
	logic [word_w-1:0] word_idx;	// Upper word bits alias
	logic              drp_en;
	wire [num_plls-1:0] fbdiv_wr;

	assign word_idx = apb.paddr[drp_word_lsb +: word_w];
	assign drp_en   = apb.psel & apb.penable & ~apb.pready;	// DRPEN, once per access

	always_ff @(posedge apb.pclk) begin
		if (reset) begin
			apb.pready <= 1'b0;
			for (int i = 0; i < DRP_WORDS; i++)
				ram[i] <= '0;
		end else begin
			apb.pready <= drp_en;	// DRPRDY one cycle after DRPEN
			if (drp_en && apb.pwrite)
				ram[word_idx] <= apb.pwdata[drp_width-1:0];
		end
	end

	always_ff @(posedge apb.pclk) begin
		if (drp_en)
			rd_q <= ram[word_idx];
	end

	assign apb.prdata  = {{(data_width-drp_width){1'b0}}, rd_q};	// Upper half reads zero
	assign apb.pslverr = 1'b0;

	////////////////////////////////////////
	// Per PLL lock and SDM capture

	wire refclk_sel_t   sel [num_plls];
	wire sdm_word_t     sdm_in [num_plls];
	wire sdm_word_t     sdm_act [num_plls];
	wire [num_plls-1:0] lock_v;
	wire [num_plls-1:0] lost_v;

	assign sel[0]    = refclk_sel0;
	assign sel[1]    = refclk_sel1;
	assign sdm_in[0] = sdm_data0;
	assign sdm_in[1] = sdm_data1;

	for (genvar i = 0; i < num_plls; i++) begin : g_pll
		logic               src_ok;
		logic [lock_w-1:0]  lock_cnt;
		logic               lock_q;
		logic               lost_q;
		logic               tog_q;
		logic [pulse_w-1:0] hi_cnt;	// Saturates at the minimum pulse
		logic               stable;
		sdm_word_t          held;
		sdm_word_t          active_q;

		assign src_ok      = source_ok(sel[i], refclk_ok);
		assign fbdiv_wr[i] = drp_en & apb.pwrite & (word_idx == word_w'(i));	// Word i is FBDIV

		always_ff @(posedge apb.pclk) begin
			if (reset || qpll_reset[i] || !src_ok || fbdiv_wr[i]) begin
				lock_cnt <= '0;
				lock_q   <= 1'b0;
			end else if (!lock_q) begin
				if (lock_cnt == lock_w'(LOCK_CYCLES - 1))
					lock_q <= 1'b1;
				lock_cnt <= lock_cnt + 1'b1;
			end
		end

		always_ff @(posedge apb.pclk) begin
			if (reset)
				lost_q <= 1'b0;
			else
				lost_q <= ~src_ok;
		end

		// Toggle width check, word taken on the falling edge
		always_ff @(posedge apb.pclk) begin
			if (reset) begin
				tog_q    <= 1'b0;
				hi_cnt   <= '0;
				stable   <= 1'b0;
				active_q <= '0;
			end else begin
				tog_q <= sdm_toggle[i];
				if (sdm_toggle[i] && !tog_q) begin
					hi_cnt <= pulse_w'(1);
					stable <= 1'b1;
				end else if (sdm_toggle[i]) begin
					if (hi_cnt != pulse_w'(sdm_min_pulse))
						hi_cnt <= hi_cnt + 1'b1;
					if (sdm_in[i] != held)
						stable <= 1'b0;	// Data moved mid pulse
				end else if (tog_q && hi_cnt == pulse_w'(sdm_min_pulse) && stable && !sdm_reset[i])
					active_q <= held;
			end
		end

		always_ff @(posedge apb.pclk) begin
			if (sdm_toggle[i] && !tog_q)
				held <= sdm_in[i];
		end

		assign lock_v[i]  = lock_q;
		assign lost_v[i]  = lost_q;
		assign sdm_act[i] = active_q;
	end

	always_comb begin
		for (int i = 0; i < num_plls; i++)
			pll_status[i] = '{lock: lock_v[i], refclk_lost: lost_v[i]};
	end

	assign sdm_active0 = sdm_act[0];
	assign sdm_active1 = sdm_act[1];

endmodule

`default_nettype wire

// File: design/quad_pll_subsys.sv
`timescale 1ns/1ps
`default_nettype none

module quad_pll_subsys import apb_pkg::*, qpll_pkg::*; #(
	parameter int LOCK_CYCLES  = 40,
	parameter int DRP_WORDS    = 16,
	parameter int PULSE_CYCLES = 3,
	parameter int HOLD_CYCLES  = 3
) (
	input wire                   pclk,
	input wire                   reset,

	// Host APB
	input wire                   psel,
	input wire                   penable,
	input wire                   pwrite,
	input wire apb_addr_t        paddr,
	input wire apb_data_t        pwdata,
	output wire apb_data_t       prdata,
	output wire                  pready,
	output wire                  pslverr,

	// Reference clock presence and PLL status
	input wire [num_refclks-1:0] refclk_ok,
	output wire [num_plls-1:0]   qpll_lock,
	output wire [num_plls-1:0]   refclk_lost
);

	apb_if drp_bus (.pclk(pclk));

	wire [num_plls-1:0]              qpll_reset;
	wire [num_plls-1:0]              sdm_reset;
	wire refclk_sel_t                refclk_sel0;
	wire refclk_sel_t                refclk_sel1;
	wire pll_status_t [num_plls-1:0] pll_status;
	wire [num_plls-1:0]              sdm_start;
	wire [num_plls-1:0]              sdm_busy;
	wire [num_plls-1:0]              sdm_toggle;
	wire sdm_word_t                  sdm_word0;
	wire sdm_word_t                  sdm_word1;
	wire sdm_word_t                  sdm_data0;
	wire sdm_word_t                  sdm_data1;
	wire sdm_word_t                  sdm_active0;
	wire sdm_word_t                  sdm_active1;

	////////////////////////////////////////
	// Control and SDM sequencers

	pll_ctrl ctrl (.pclk, .reset, .psel, .penable, .pwrite, .paddr, .pwdata,
		.prdata, .pready, .pslverr, .drp(drp_bus.requester),
		.qpll_reset, .sdm_reset, .refclk_sel0, .refclk_sel1, .pll_status,
		.sdm_start, .sdm_word0, .sdm_word1, .sdm_busy, .sdm_active0, .sdm_active1);

	sdm_loader #(.PULSE_CYCLES(PULSE_CYCLES), .HOLD_CYCLES(HOLD_CYCLES)) loader0 (
		.pclk, .reset, .start(sdm_start[0]), .word(sdm_word0),
		.sdm_data(sdm_data0), .sdm_toggle(sdm_toggle[0]), .busy(sdm_busy[0]));

	sdm_loader #(.PULSE_CYCLES(PULSE_CYCLES), .HOLD_CYCLES(HOLD_CYCLES)) loader1 (
		.pclk, .reset, .start(sdm_start[1]), .word(sdm_word1),
		.sdm_data(sdm_data1), .sdm_toggle(sdm_toggle[1]), .busy(sdm_busy[1]));

	////////////////////////////////////////
	// PLL model

	quad_pll #(.LOCK_CYCLES(LOCK_CYCLES), .DRP_WORDS(DRP_WORDS)) pll (
		.apb(drp_bus.completer), .reset, .refclk_ok, .refclk_sel0, .refclk_sel1,
		.qpll_reset, .sdm_reset, .sdm_data0, .sdm_data1, .sdm_toggle,
		.pll_status, .sdm_active0, .sdm_active1);

	for (genvar i = 0; i < num_plls; i++) begin : g_status
		assign qpll_lock[i]   = pll_status[i].lock;
		assign refclk_lost[i] = pll_status[i].refclk_lost;
	end

endmodule

`default_nettype wire

// File: design/sdm_loader.sv
`timescale 1ns/1ps
`default_nettype none

module sdm_loader import qpll_pkg::*; #(
	parameter int PULSE_CYCLES = 3,	// Toggle high time
	parameter int HOLD_CYCLES  = 3	// Toggle low before data may change
) (
	input wire        pclk,
	input wire        reset,
	input wire        start,
	input wire sdm_word_t word,
	output sdm_word_t sdm_data,
	output logic      sdm_toggle,
	output logic      busy
);

	localparam int cnt_max = (PULSE_CYCLES > HOLD_CYCLES) ? PULSE_CYCLES : HOLD_CYCLES;
	localparam int cnt_w   = $clog2(cnt_max + 1);

	typedef enum logic [1:0] {
		st_idle,
		st_setup,	// Data out, toggle still low
		st_pulse,
		st_hold
	} state_t;

	state_t           state;
	logic [cnt_w-1:0] cnt;

	always_ff @(posedge pclk) begin
		if (reset) begin
			state <= st_idle;
			cnt   <= '0;
		end else begin
			case (state)
				st_idle: if (start) state <= st_setup;
				st_setup: begin
					state <= st_pulse;
					cnt   <= '0;
				end
				st_pulse: begin
					if (cnt == cnt_w'(PULSE_CYCLES - 1)) begin
						state <= st_hold;
						cnt   <= '0;
					end else
						cnt <= cnt + 1'b1;
				end
				st_hold: begin
					if (cnt == cnt_w'(HOLD_CYCLES - 1))
						state <= st_idle;	// Data free to change again
					else
						cnt <= cnt + 1'b1;
				end
				default: state <= st_idle;
			endcase
		end
	end

	// Word latched once, stable until hold ends
	always_ff @(posedge pclk) begin
		if (start && state == st_idle)
			sdm_data <= word;
	end

	assign sdm_toggle = (state == st_pulse);
	assign busy       = (state != st_idle);

endmodule

`default_nettype wire

// File: quad_pll_subsys.f
design/qpll_pkg.sv
design/apb_pkg.sv
design/apb_if.sv
design/sdm_loader.sv
design/pll_ctrl.sv
design/quad_pll.sv
design/quad_pll_subsys.sv
testbench/quad_pll_subsys_asserts.sv
testbench/quad_pll_subsys_tb.sv

// File: testbench/quad_pll_subsys_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module quad_pll_subsys_asserts import apb_pkg::*, qpll_pkg::*; #(
	parameter int PULSE_CYCLES = 3
) (
	input wire                pclk,
	input wire                reset,
	input wire                psel,
	input wire                penable,
	input wire                pwrite,
	input wire                pready,
	input wire apb_addr_t     paddr,
	input wire apb_data_t     prdata,
	input wire                drp_psel,
	input wire                drp_pready,
	input wire [num_plls-1:0] sdm_toggle
);

	int hi_len [num_plls];	// Consecutive high cycles per toggle

	always_ff @(posedge pclk) begin
		for (int i = 0; i < num_plls; i++) begin
			if (reset)
				hi_len[i] <= 0;
			else
				hi_len[i] <= sdm_toggle[i] ? hi_len[i] + 1 : 0;
		end
	end

	////////////////////////////////////////
	// SDM toggle

	for (genvar i = 0; i < num_plls; i++) begin : g_toggle
		// Width counted up to the falling edge
		toggle_width: assert property (@(posedge pclk) disable iff (reset)
			$fell(sdm_toggle[i]) |-> hi_len[i] == PULSE_CYCLES)
			else $error("SDM toggle %0d high for %0d cycles", i, hi_len[i]);
	end

	toggle_low_in_reset: assert property (@(posedge pclk)
		(reset && $past(reset)) |-> sdm_toggle == '0)
		else $error("SDM toggle high during reset");

	////////////////////////////////////////
	// Host bus

	// Registered DRP ready only inside a selected access
	pready_needs_psel: assert property (@(posedge pclk) disable iff (reset)
		drp_pready |-> drp_psel)
		else $error("DRP pready high without psel");

	drp_upper_zero: assert property (@(posedge pclk) disable iff (reset)
		(psel && penable && pready && !pwrite && paddr[drp_window_bit])
		|-> prdata[data_width-1:drp_width] == '0)
		else $error("DRP read data upper half not zero");

endmodule

bind quad_pll_subsys quad_pll_subsys_asserts #(.PULSE_CYCLES(PULSE_CYCLES)) asserts_i (
	.pclk(pclk), .reset(reset), .psel(psel), .penable(penable), .pwrite(pwrite),
	.pready(pready), .paddr(paddr), .prdata(prdata),
	.drp_psel(drp_bus.psel), .drp_pready(drp_bus.pready), .sdm_toggle(sdm_toggle));

`default_nettype wire

// File: testbench/quad_pll_subsys_tb.sv
`timescale 1ns/1ps
`default_nettype none

module quad_pll_subsys_tb import apb_pkg::*, qpll_pkg::*; ();

	localparam int LOCK_CYCLES  = 40;
	localparam int DRP_WORDS    = 16;
	localparam int PULSE_CYCLES = 3;
	localparam int HOLD_CYCLES  = 3;

	localparam int clk_period   = 100;
	localparam int reset_cycles = 8;
	localparam int n_drp        = 32;	// Random DRP accesses
	localparam int n_unmapped   = 4;
	localparam int lock_margin  = 12;	// Status poll granularity
	localparam int busy_limit   = 1 + PULSE_CYCLES + HOLD_CYCLES + 8;
	localparam int xfer_cycles  = 5;	// Setup, access, wait, idle, slack
	localparam int n_xfers      = 4 + n_drp + DRP_WORDS + 12 + 12 + 3 * n_unmapped;
	localparam int cycle_limit  = reset_cycles + n_xfers * xfer_cycles
		+ 8 * (LOCK_CYCLES + lock_margin + xfer_cycles) + 2 * (busy_limit + xfer_cycles) + 100;

	localparam pll_status_t st_locked = '{lock: 1'b1, refclk_lost: 1'b0};
	localparam pll_status_t st_lost   = '{lock: 1'b0, refclk_lost: 1'b1};
	localparam pll_status_t st_down   = '{lock: 1'b0, refclk_lost: 1'b0};

	logic                   pclk;
	logic                   reset;
	logic                   psel;
	logic                   penable;
	logic                   pwrite;
	apb_addr_t              paddr;
	apb_data_t              pwdata;
	apb_data_t              prdata;
	logic                   pready;
	logic                   pslverr;
	logic [num_refclks-1:0] refclk_ok;
	logic [num_plls-1:0]    qpll_lock;
	logic [num_plls-1:0]    refclk_lost;

	// Reference model
	apb_data_t   model_ctrl;
	drp_data_t   model_drp [DRP_WORDS];
	sdm_word_t   model_active [num_plls];

	logic [31:0] rng;
	int          cycle_count;
	int          errors;
	int          test_errors;
	int          tests_run;
	int          tests_failed;
	string       current_test;

	quad_pll_subsys #(
		.LOCK_CYCLES(LOCK_CYCLES),
		.DRP_WORDS(DRP_WORDS),
		.PULSE_CYCLES(PULSE_CYCLES),
		.HOLD_CYCLES(HOLD_CYCLES)
	) quad_pll_subsys_i (
		.pclk, .reset, .psel, .penable, .pwrite, .paddr, .pwdata,
		.prdata, .pready, .pslverr, .refclk_ok, .qpll_lock, .refclk_lost
	);

	always #(clk_period / 2) pclk = ~pclk;

	// Run limit
	always @(posedge pclk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= cycle_limit) begin
			$display("Timeout after %0d cycles, tests did not finish", cycle_count);
			$display("TEST RESULT: FAIL");
			$finish;
		end
	end

	////////////////////////////////////////
	// Helpers

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// Window bit set, word index from bit 2
	function automatic apb_addr_t drp_addr(input int word);
		apb_addr_t a;
		a                 = '0;
		a[drp_window_bit] = 1'b1;
		a[9:2]            = word[7:0];
		return a;
	endfunction

	// Lock in 1:0, refclk_lost in 3:2
	function automatic pll_status_t status_of(input apb_data_t word, input int pll);
		pll_status_t st;
		st.lock        = word[pll];
		st.refclk_lost = word[num_plls + pll];
		return st;
	endfunction

	task automatic check_data(input string what, input apb_data_t expected, input apb_data_t actual);
		if (actual !== expected) begin
			$display("** Error [%s] %s: expected 0x%08h, actual 0x%08h",
				current_test, what, expected, actual);
			test_errors++;
		end
	endtask

	task automatic check_status(input string what, input pll_status_t expected,
		input pll_status_t actual);
		if (actual !== expected) begin
			$display("** Error [%s] %s: expected lock %b lost %b, actual lock %b lost %b",
				current_test, what, expected.lock, expected.refclk_lost,
				actual.lock, actual.refclk_lost);
			test_errors++;
		end
	endtask

	task automatic check_sdm(input string what, input sdm_word_t expected, input sdm_word_t actual);
		if (actual !== expected) begin
			$display("** Error [%s] %s: expected 0x%07h, actual 0x%07h",
				current_test, what, expected, actual);
			test_errors++;
		end
	endtask

	task automatic check_flag(input string what, input logic expected, input logic actual);
		if (actual !== expected) begin
			$display("** Error [%s] %s: expected %b, actual %b", current_test, what, expected, actual);
			test_errors++;
		end
	endtask

	task automatic begin_test(input string name);
		current_test = name;
		test_errors  = 0;
	endtask

	task automatic end_test();
		tests_run++;
		errors += test_errors;
		if (test_errors == 0)
			$display("test %s: ok", current_test);
		else begin
			tests_failed++;
			$display("test %s: %0d errors", current_test, test_errors);
		end
	endtask

	////////////////////////////////////////
	// APB host

	task automatic apb_access(input logic write, input apb_addr_t addr, input apb_data_t wdata,
		output apb_data_t rdata, output logic err);
		int waits;
		waits = 0;
		rdata = '0;
		err   = 1'b0;
		@(negedge pclk);
		psel    = 1'b1;	// Setup phase
		penable = 1'b0;
		pwrite  = write;
		paddr   = addr;
		pwdata  = wdata;
		@(negedge pclk);
		penable = 1'b1;
		#(clk_period / 4);	// Mid low phase, response settled
		while (!pready && waits < 4) begin
			@(negedge pclk);
			#(clk_period / 4);
			waits++;
		end
		if (pready) begin
			rdata = prdata;
			err   = pslverr;
		end else begin
			$display("[%s] APB access to 0x%03h never got pready", current_test, addr);
			test_errors++;
		end
		@(negedge pclk);	// Completion edge has passed
		psel    = 1'b0;
		penable = 1'b0;
	endtask

	task automatic apb_write(input apb_addr_t addr, input apb_data_t wdata, output logic err);
		apb_data_t ignored;
		apb_access(1'b1, addr, wdata, ignored, err);
	endtask

	task automatic apb_read(input apb_addr_t addr, output apb_data_t rdata, output logic err);
		apb_access(1'b0, addr, '0, rdata, err);
	endtask

	// Random junk in the unused bits 7 and 31:11
	task automatic write_ctrl(input logic [1:0] pll_rst, input logic [1:0] sdm_rst,
		input refclk_sel_t sel0, input refclk_sel_t sel1);
		logic err;
		model_ctrl = {21'b0, sel1, 1'b0, sel0, sdm_rst, pll_rst};
		rng        = xorshift(rng);
		apb_write(ctrl_addr, model_ctrl | (rng & 32'hfffff880), err);
		check_flag("ctrl write pslverr", 1'b0, err);
	endtask

	task automatic wait_lock(input int pll, output pll_status_t st);
		apb_data_t word;
		logic      err;
		int        start;
		start = cycle_count;
		do begin
			apb_read(status_addr, word, err);
			st = status_of(word, pll);
		end while (!st.lock && cycle_count - start < LOCK_CYCLES + lock_margin);
	endtask

	task automatic wait_idle(input int pll, output logic busy);
		apb_data_t word;
		logic      err;
		int        start;
		start = cycle_count;
		do begin
			apb_read(status_addr, word, err);
			busy = word[2 * num_plls + pll];	// Busy in 5:4
		end while (busy && cycle_count - start < busy_limit);
	endtask

	////////////////////////////////////////
	// Tests

	initial begin
		apb_data_t   rdata;
		logic        err;
		logic        busy;
		pll_status_t st;
		sdm_word_t   word;
		apb_addr_t   addr;
		int          w;
		int          src;

		pclk         = 1'b0;
		reset        = 1'b1;
		psel         = 1'b0;
		penable      = 1'b0;
		pwrite       = 1'b0;
		paddr        = '0;
		pwdata       = '0;
		refclk_ok    = '1;	// All sources present
		rng          = 32'h8b23450b;
		cycle_count  = 0;
		errors       = 0;
		tests_run    = 0;
		tests_failed = 0;
		model_ctrl   = {21'b0, sel_local0, 1'b0, sel_local0, 2'b11, 2'b11};
		for (int i = 0; i < DRP_WORDS; i++)
			model_drp[i] = '0;
		for (int i = 0; i < num_plls; i++)
			model_active[i] = '0;
		repeat (reset_cycles) @(negedge pclk);
		reset = 1'b0;

		begin_test("reset_values");
		apb_read(ctrl_addr, rdata, err);
		check_data("ctrl", model_ctrl, rdata);
		check_flag("ctrl pslverr", 1'b0, err);
		apb_read(status_addr, rdata, err);
		check_data("status", '0, rdata);
		apb_read(sdm_active0_addr, rdata, err);
		check_sdm("sdm_active0", model_active[0], rdata[sdm_width-1:0]);
		apb_read(sdm_active1_addr, rdata, err);
		check_sdm("sdm_active1", model_active[1], rdata[sdm_width-1:0]);
		end_test();

		begin_test("drp_random");
		for (int n = 0; n < n_drp; n++) begin
			rng  = xorshift(rng);
			w    = int'(rng[11:4] % DRP_WORDS);
			addr = drp_addr(w);
			if (rng[0]) begin
				rng = xorshift(rng);
				apb_write(addr, rng, err);	// Upper half ignored
				model_drp[w] = rng[drp_width-1:0];
			end else begin
				apb_read(addr, rdata, err);
				check_data($sformatf("drp word %0d", w),
					{{(data_width-drp_width){1'b0}}, model_drp[w]}, rdata);
			end
			check_flag("drp pslverr", 1'b0, err);
		end
		for (int i = 0; i < DRP_WORDS; i++) begin	// Full sweep
			apb_read(drp_addr(i), rdata, err);
			check_data($sformatf("drp sweep %0d", i),
				{{(data_width-drp_width){1'b0}}, model_drp[i]}, rdata);
		end
		end_test();

		begin_test("pll_lock");
		write_ctrl(2'b00, 2'b11, sel_local0, sel_local1);
		for (int p = 0; p < num_plls; p++) begin
			wait_lock(p, st);
			check_status($sformatf("pll%0d lock", p), st_locked, st);
		end
		rng = xorshift(rng);
		src = 3 + int'(rng % 4);	// North or south, PLL1 stays on local 1
		@(negedge pclk);
		refclk_ok = ~(6'b1 << (src - 1));
		write_ctrl(2'b00, 2'b11, refclk_sel_t'(src), sel_local1);
		apb_read(status_addr, rdata, err);
		check_status("pll0 on missing source", st_lost, status_of(rdata, 0));
		check_status("pll1 on local 1", st_locked, status_of(rdata, 1));
		check_status("pll0 status ports", st_lost, pll_status_t'({qpll_lock[0], refclk_lost[0]}));
		check_status("pll1 status ports", st_locked, pll_status_t'({qpll_lock[1], refclk_lost[1]}));
		@(negedge pclk);
		refclk_ok = '1;
		write_ctrl(2'b00, 2'b11, sel_local0, sel_local1);
		end_test();

		begin_test("fbdiv_relock");
		for (int p = 0; p < num_plls; p++) begin
			for (int q = 0; q < num_plls; q++) begin
				wait_lock(q, st);
				check_status($sformatf("pll%0d locked before write", q), st_locked, st);
			end
			rng = xorshift(rng);
			apb_write(drp_addr(p), rng, err);	// Feedback divider word
			model_drp[p] = rng[drp_width-1:0];
			apb_read(status_addr, rdata, err);
			check_status($sformatf("pll%0d after divider write", p), st_down, status_of(rdata, p));
			check_status("other pll untouched", st_locked, status_of(rdata, 1 - p));
			wait_lock(p, st);
			check_status($sformatf("pll%0d relock", p), st_locked, st);
			apb_read(drp_addr(p), rdata, err);
			check_data("divider readback", {{(data_width-drp_width){1'b0}}, model_drp[p]}, rdata);
		end
		end_test();

		begin_test("sdm_load");
		write_ctrl(2'b00, 2'b00, sel_local0, sel_local1);
		for (int p = 0; p < num_plls; p++) begin
			addr = (p == 0) ? sdm0_addr : sdm1_addr;
			rng  = xorshift(rng);
			word = rng[sdm_width-1:0];
			apb_write(addr, rng, err);
			check_flag("first sdm write pslverr", 1'b0, err);
			model_active[p] = word;
			rng = xorshift(rng);
			apb_write(addr, rng, err);	// Loader still running
			check_flag("sdm write while busy pslverr", 1'b1, err);
			wait_idle(p, busy);
			check_flag("loader busy after sequence", 1'b0, busy);
			apb_read((p == 0) ? sdm_active0_addr : sdm_active1_addr, rdata, err);
			check_sdm($sformatf("sdm_active%0d", p), model_active[p], rdata[sdm_width-1:0]);
			apb_read(addr, rdata, err);
			check_sdm("sdm word after dropped write", word, rdata[sdm_width-1:0]);
		end
		end_test();

		begin_test("unmapped");
		for (int n = 0; n < n_unmapped; n++) begin
			rng  = xorshift(rng);
			addr = {2'b00, rng[9:2], 2'b00};	// Control window, word aligned
			if (addr <= sdm_active1_addr)
				addr = addr + 12'h018;
			apb_read(addr, rdata, err);
			check_data($sformatf("read 0x%03h", addr), '0, rdata);
			check_flag("unmapped read pslverr", 1'b1, err);
			apb_write(addr, rng, err);
			check_flag("unmapped write pslverr", 1'b1, err);
		end
		apb_read(ctrl_addr, rdata, err);
		check_data("ctrl after unmapped writes", model_ctrl, rdata);
		end_test();

		$display("%0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
		if (errors == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire
